// File: tlb_mgmt_top.f
+incdir+.
tlb_pkg.sv
tlb_cmd_decode.sv
tlb_entry_array.sv
tlb_csr_bank.sv
tlb_mgmt_top.sv
tb_tlb_mgmt.sv

// File: run.sh
#!/bin/sh
# compile with Verilator, run, then decide pass or fail from the log
set -e
cd "$(dirname "$0")"
verilator --binary --assert -j 0 --top-module tb_tlb_mgmt -f tlb_mgmt_top.f -o sim_tlb_mgmt
./obj_dir/sim_tlb_mgmt > sim.log 2>&1 || true
cat sim.log
if grep -q "Test completed successfully" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// File: tb_tlb_mgmt.sv
`timescale 1ns/100ps
`include "tlb_defines.svh"

module tb_tlb_mgmt;
    import tlb_pkg::*;

    localparam int WAIT_LIMIT = 500;

    logic       clk;
    logic       reset;
    logic       cmd_valid;
    tlb_cmd_t   cmd;
    logic       cmd_credit;
    tlb_csr_t   csr;
    logic       done_valid;
    tlb_op_e    done_op;
    tlb_csr_t   m_csr = '0;
    tlb_entry_t m_ent [`TLB_ENTRY_NUM] = '{default: '0};
    tlb_op_e    last_op = CSR_WR;
    tlb_cmd_t   sent [$];
    int         retired = 0;
    int         spent = 0;
    int         returned;
    int         host_credits;
    int         cyc;

    tlb_mgmt_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_credit (cmd_credit),
        .csr        (csr),
        .done_valid (done_valid),
        .done_op    (done_op)
    );

    assign host_credits = `TLB_CMD_CREDITS - spent + returned;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    function automatic logic inv_match(input tlb_entry_t e, input tlb_cmd_t c);
        logic asid_eq;
        logic vppn_eq;
        asid_eq = (e.asid == c.inv_asid);
        vppn_eq = (e.vppn == c.inv_vppn);
        case (c.inv_op)
            5'd0, 5'd1: return 1'b1;
            5'd2: return e.g;
            5'd3: return !e.g;
            5'd4: return !e.g && asid_eq;
            5'd5: return !e.g && asid_eq && vppn_eq;
            5'd6: return (e.g || asid_eq) && vppn_eq;
            default: return 1'b0;  // undefined ops leave every entry alone
        endcase
    endfunction

    task automatic model_apply(input tlb_cmd_t c, input tlb_idx_t fill_at);
        tlb_entry_t ent;
        case (c.op)
            CSR_WR: begin
                case (c.csr_sel)
                    SEL_ASID:    m_csr.asid      = csr_asid_t'(c.data);
                    SEL_TLBEHI:  m_csr.tlbehi    = csr_tlbehi_t'(c.data);
                    SEL_TLBELO0: m_csr.tlbelo[0] = csr_tlbelo_t'(c.data);
                    SEL_TLBELO1: m_csr.tlbelo[1] = csr_tlbelo_t'(c.data);
                    SEL_TLBIDX:  m_csr.tlbidx    = csr_tlbidx_t'(c.data);
                    default:     m_csr.estat     = csr_estat_t'(c.data);
                endcase
            end
            SRCH: begin
                m_csr.tlbidx.ne = 1'b1;
                for (int i = 0; i < `TLB_ENTRY_NUM; i++) begin
                    if (m_ent[i].e && (m_ent[i].vppn == m_csr.tlbehi.vppn)
                        && (m_ent[i].g || (m_ent[i].asid == m_csr.asid.asid))) begin
                        m_csr.tlbidx.ne    = 1'b0;
                        m_csr.tlbidx.index = tlb_idx_t'(i);  // the last hit is the highest index
                    end
                end
            end
            RD: begin
                ent = m_ent[m_csr.tlbidx.index];
                if (ent.e) begin
                    m_csr.tlbidx.ps   = ent.ps;
                    m_csr.tlbehi.vppn = ent.vppn;
                    m_csr.asid.asid   = ent.asid;
                    for (int j = 0; j < 2; j++) begin
                        m_csr.tlbelo[j]     = '0;
                        m_csr.tlbelo[j].ppn = ent.phy[j].ppn;
                        m_csr.tlbelo[j].plv = ent.phy[j].plv;
                        m_csr.tlbelo[j].mat = ent.phy[j].mat;
                        m_csr.tlbelo[j].d   = ent.phy[j].d;
                        m_csr.tlbelo[j].v   = ent.phy[j].v;
                        m_csr.tlbelo[j].g   = ent.g;
                    end
                end else begin
                    m_csr.tlbidx.ne = 1'b1;
                    m_csr.tlbidx.ps = '0;
                    m_csr.tlbehi    = '0;
                    m_csr.tlbelo    = '0;
                    m_csr.asid.asid = '0;
                end
            end
            WR, FILL: begin
                ent      = '0;
                ent.e    = (m_csr.estat.ecode == `TLB_ECODE_TLBR) ? !m_csr.tlbidx.ne : 1'b1;
                ent.g    = m_csr.tlbelo[0].g & m_csr.tlbelo[1].g;
                ent.vppn = m_csr.tlbehi.vppn;
                ent.ps   = m_csr.tlbidx.ps;
                ent.asid = m_csr.asid.asid;
                for (int j = 0; j < 2; j++) begin
                    ent.phy[j] = {m_csr.tlbelo[j].ppn, m_csr.tlbelo[j].plv,
                                  m_csr.tlbelo[j].mat, m_csr.tlbelo[j].d, m_csr.tlbelo[j].v};
                end
                m_ent[(c.op == FILL) ? fill_at : m_csr.tlbidx.index] = ent;
            end
            default: begin
                for (int i = 0; i < `TLB_ENTRY_NUM; i++) begin
                    if (inv_match(m_ent[i], c)) begin
                        m_ent[i].e = 1'b0;
                    end
                end
            end
        endcase
    endtask

    always @(posedge clk) begin
        if (reset) begin
            cyc      <= 0;
            returned <= 0;
        end else begin
            cyc <= cyc + 1;
            if (cmd_credit) begin
                returned <= returned + 1;
            end
        end
    end

    // FILL took the counter value of the execute edge, two edges before this point
    always @(negedge clk) begin
        if (!reset && done_valid) begin
            if (retired >= sent.size()) begin
                report_fail("done_valid came while no command was outstanding");
            end else begin
                last_op = sent[retired].op;
                model_apply(sent[retired], tlb_idx_t'(cyc - 2));
                retired = retired + 1;
            end
        end
    end

    a_csr_model: assert property (@(posedge clk) disable iff (reset) csr == m_csr)
        else report_fail($sformatf("mismatch at %0d ns: csr %h, model %h", $time, csr, m_csr));
    a_done_op: assert property (@(posedge clk) disable iff (reset)
        done_valid |-> done_op == last_op)
        else report_fail($sformatf("mismatch at %0d ns: done_op %s, model %s",
                                   $time, done_op.name(), last_op.name()));
    a_credit_range: assert property (@(posedge clk) disable iff (reset)
        host_credits >= 0 && host_credits <= `TLB_CMD_CREDITS)
        else report_fail($sformatf("host credit count %0d out of range", host_credits));

    function automatic tlb_cmd_t make_cmd(input tlb_op_e op, input csr_sel_e sel,
                                          input logic [`TLB_DATA_WID-1:0] data);
        tlb_cmd_t c;
        c         = '0;
        c.op      = op;
        c.csr_sel = sel;
        c.data    = data;
        return c;
    endfunction

    task automatic send(input tlb_cmd_t c);
        int waited;
        waited = 0;
        while (host_credits == 0) begin
            if (waited == WAIT_LIMIT) begin
                report_fail("timed out waiting for a command credit");
            end
            waited++;
            @(negedge clk);
        end
        cmd_valid = 1'b1;
        cmd       = c;
        spent     = spent + 1;
        sent.push_back(c);
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while ((retired != sent.size()) || (host_credits != `TLB_CMD_CREDITS)) begin
            if (waited == WAIT_LIMIT) begin
                report_fail("timed out waiting for outstanding commands to retire");
            end
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic load_entry(input asid_t asid, input vppn_t vppn, input logic g0,
                              input logic g1, input tlb_idx_t idx, input logic ne);
        csr_tlbelo_t lo;
        csr_tlbidx_t ix;
        send(make_cmd(CSR_WR, SEL_ASID, 32'(asid)));
        send(make_cmd(CSR_WR, SEL_TLBEHI, {vppn, 13'd0}));
        for (int j = 0; j < 2; j++) begin
            lo     = '0;
            lo.ppn = ppn_t'($urandom);
            lo.plv = 2'($urandom);
            lo.mat = 2'($urandom);
            lo.d   = 1'($urandom);
            lo.v   = 1'($urandom);
            lo.g   = (j == 0) ? g0 : g1;
            send(make_cmd(CSR_WR, (j == 0) ? SEL_TLBELO0 : SEL_TLBELO1, lo));
        end
        ix       = '0;
        ix.index = idx;
        ix.ps    = 6'd12 + 6'($urandom % 4);
        ix.ne    = ne;
        send(make_cmd(CSR_WR, SEL_TLBIDX, ix));
    endtask

    task automatic search(input asid_t asid, input vppn_t vppn);
        send(make_cmd(CSR_WR, SEL_ASID, 32'(asid)));
        send(make_cmd(CSR_WR, SEL_TLBEHI, {vppn, 13'd0}));
        send(make_cmd(SRCH, SEL_ASID, '0));
    endtask

    initial begin
        tlb_cmd_t c;
        asid_t    asids [2];
        vppn_t    vppns [2];
        logic     g;
        void'($urandom(98868));
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // back-to-back CSR writes outrun the issue rate and use up every credit
        load_entry(10'h015, 19'h12345, 1'b1, 1'b0, 4'd5, 1'b0);
        wait_idle();
        send(make_cmd(WR, SEL_ASID, '0));
        send(make_cmd(CSR_WR, SEL_TLBEHI, '0));
        send(make_cmd(CSR_WR, SEL_ASID, '0));
        send(make_cmd(RD, SEL_ASID, '0));
        send(make_cmd(CSR_WR, SEL_TLBIDX, 32'd9));
        send(make_cmd(RD, SEL_ASID, '0));  // entry 9 was never written
        wait_idle();

        load_entry(10'h003, 19'h00a11, 1'b1, 1'b1, 4'd2, 1'b0);
        send(make_cmd(WR, SEL_ASID, '0));
        load_entry(10'h004, 19'h00b22, 1'b1, 1'b0, 4'd7, 1'b0);
        send(make_cmd(WR, SEL_ASID, '0));
        search(10'h004, 19'h00b22);
        search(10'h3ff, 19'h00a11);
        search(10'h3ff, 19'h00b22);
        wait_idle();

        send(make_cmd(CSR_WR, SEL_ESTAT, {10'd0, `TLB_ECODE_TLBR, 16'd0}));
        load_entry(10'h006, 19'h00c33, 1'b0, 1'b0, 4'd0, 1'b1);
        send(make_cmd(FILL, SEL_ASID, '0));
        search(10'h006, 19'h00c33);
        send(make_cmd(CSR_WR, SEL_TLBIDX, 32'd0));
        send(make_cmd(FILL, SEL_ASID, '0));
        search(10'h006, 19'h00c33);
        send(make_cmd(RD, SEL_ASID, '0));
        send(make_cmd(CSR_WR, SEL_ESTAT, '0));
        wait_idle();

        asids = '{10'h011, 10'h022};
        vppns = '{19'h01000, 19'h01001};
        for (int k = 0; k < 8; k++) begin
            for (int i = 0; i < `TLB_ENTRY_NUM; i += 2) begin
                g = 1'($urandom);
                load_entry(asids[1'($urandom)], vppns[1'($urandom)], g, g, tlb_idx_t'(i), 1'b0);
                send(make_cmd(WR, SEL_ASID, '0));
            end
            c          = make_cmd(INV, SEL_ASID, '0);
            c.inv_op   = (k == 7) ? 5'd9 : 5'(k);
            c.inv_asid = asids[1'($urandom)];
            c.inv_vppn = vppns[1'($urandom)];
            send(c);
            for (int a = 0; a < 2; a++) begin
                for (int v = 0; v < 2; v++) begin
                    search(asids[a], vppns[v]);
                end
            end
            wait_idle();
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: tlb_mgmt_top.sv
`timescale 1ns/100ps
`include "tlb_defines.svh"

module tlb_mgmt_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              cmd_valid,
    input  tlb_pkg::tlb_cmd_t cmd,
    output logic              cmd_credit,
    output tlb_pkg::tlb_csr_t csr,
    output logic              done_valid,
    output tlb_pkg::tlb_op_e  done_op
);
    import tlb_pkg::*;

    logic        exec_valid;
    tlb_exec_t   exec;
    logic        res_valid;
    tlb_result_t res;

    tlb_cmd_decode u_decode (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_credit (cmd_credit),
        .retire     (done_valid),  // done also frees the issue slot
        .exec_valid (exec_valid),
        .exec       (exec)
    );

    tlb_entry_array u_array (
        .clk        (clk),
        .reset      (reset),
        .exec_valid (exec_valid),
        .exec       (exec),
        .csr        (csr),
        .res_valid  (res_valid),
        .res        (res)
    );

    tlb_csr_bank u_csr_bank (
        .clk        (clk),
        .reset      (reset),
        .res_valid  (res_valid),
        .res        (res),
        .csr        (csr),
        .done_valid (done_valid),
        .done_op    (done_op)
    );

endmodule

// File: tlb_csr_bank.sv
`timescale 1ns/100ps
`include "tlb_defines.svh"

module tlb_csr_bank (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 res_valid,
    input  tlb_pkg::tlb_result_t res,
    output tlb_pkg::tlb_csr_t    csr,
    output logic                 done_valid,
    output tlb_pkg::tlb_op_e     done_op
);
    import tlb_pkg::*;

    csr_asid_t   wr_asid;
    csr_tlbehi_t wr_tlbehi;
    csr_tlbelo_t wr_tlbelo;
    csr_tlbidx_t wr_tlbidx;
    csr_estat_t  wr_estat;
    tlb_entry_t  ent;

    assign ent = res.rd_entry;

    // host data with the reserved bits forced to zero
    always_comb begin
        wr_asid          = csr_asid_t'(res.data);
        wr_asid.rsv      = '0;
        wr_tlbehi        = csr_tlbehi_t'(res.data);
        wr_tlbehi.rsv    = '0;
        wr_tlbelo        = csr_tlbelo_t'(res.data);
        wr_tlbelo.rsv_hi = '0;
        wr_tlbelo.rsv    = 1'b0;
        wr_tlbidx        = csr_tlbidx_t'(res.data);
        wr_tlbidx.rsv1   = 1'b0;
        wr_tlbidx.rsv0   = '0;
        wr_estat         = '0;
        wr_estat.ecode   = res.data[21:16];  // only the exception code is kept
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            csr        <= '0;
            done_valid <= 1'b0;
        end else begin
            done_valid <= res_valid;
            if (res_valid) begin
                case (res.op)
                    CSR_WR: begin
                        case (res.csr_sel)
                            SEL_ASID:    csr.asid      <= wr_asid;
                            SEL_TLBEHI:  csr.tlbehi    <= wr_tlbehi;
                            SEL_TLBELO0: csr.tlbelo[0] <= wr_tlbelo;
                            SEL_TLBELO1: csr.tlbelo[1] <= wr_tlbelo;
                            SEL_TLBIDX:  csr.tlbidx    <= wr_tlbidx;
                            SEL_ESTAT:   csr.estat     <= wr_estat;
                            default: ;
                        endcase
                    end
                    SRCH: begin
                        csr.tlbidx.ne <= ~res.found;
                        if (res.found) begin
                            csr.tlbidx.index <= res.srch_idx;  // a miss keeps the old index
                        end
                    end
                    RD: begin
                        if (ent.e) begin
                            csr.tlbidx.ps   <= ent.ps;
                            csr.tlbehi.vppn <= ent.vppn;
                            csr.asid.asid   <= ent.asid;
                            for (int j = 0; j < 2; j++) begin
                                csr.tlbelo[j].ppn <= ent.phy[j].ppn;
                                csr.tlbelo[j].plv <= ent.phy[j].plv;
                                csr.tlbelo[j].mat <= ent.phy[j].mat;
                                csr.tlbelo[j].d   <= ent.phy[j].d;
                                csr.tlbelo[j].v   <= ent.phy[j].v;
                                csr.tlbelo[j].g   <= ent.g;
                            end
                        end else begin
                            csr.tlbidx.ne <= 1'b1;
                            csr.tlbidx.ps <= '0;
                            csr.tlbehi    <= '0;
                            csr.tlbelo    <= '0;
                            csr.asid.asid <= '0;
                        end
                    end
                    default: ;  // WR, FILL and INV only touch the array
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid) begin
            done_op <= res.op;
        end
    end

endmodule

// File: tlb_entry_array.sv
`timescale 1ns/100ps
`include "tlb_defines.svh"

module tlb_entry_array (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 exec_valid,
    input  tlb_pkg::tlb_exec_t   exec,
    input  tlb_pkg::tlb_csr_t    csr,
    output logic                 res_valid,
    output tlb_pkg::tlb_result_t res
);
    import tlb_pkg::*;

    tlb_entry_t                entries [`TLB_ENTRY_NUM];
    tlb_idx_t                  fill_idx;
    tlb_idx_t                  wr_idx;
    tlb_entry_t                new_entry;
    logic [`TLB_ENTRY_NUM-1:0] inv_hit;
    logic                      srch_found;
    tlb_idx_t                  srch_idx;
    logic                      do_srch;
    logic                      do_rd;
    logic                      do_wr;
    logic                      do_fill;
    logic                      do_inv;

    assign do_srch = exec_valid && (exec.op == SRCH);
    assign do_rd   = exec_valid && (exec.op == RD);
    assign do_wr   = exec_valid && (exec.op == WR);
    assign do_fill = exec_valid && (exec.op == FILL);
    assign do_inv  = exec_valid && (exec.op == INV);

    assign wr_idx = do_fill ? fill_idx : csr.tlbidx.index;

    // fill slot is just whatever the counter shows on that cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            fill_idx <= '0;
        end else begin
            fill_idx <= fill_idx + 1'b1;
        end
    end

    always_comb begin
        if (csr.estat.ecode == `TLB_ECODE_TLBR) begin
            new_entry.e = ~csr.tlbidx.ne;  // refill handler may load an invalid entry
        end else begin
            new_entry.e = 1'b1;
        end
        new_entry.g    = csr.tlbelo[0].g & csr.tlbelo[1].g;
        new_entry.vppn = csr.tlbehi.vppn;
        new_entry.ps   = csr.tlbidx.ps;
        new_entry.asid = csr.asid.asid;
        for (int j = 0; j < 2; j++) begin
            new_entry.phy[j].ppn = csr.tlbelo[j].ppn;
            new_entry.phy[j].plv = csr.tlbelo[j].plv;
            new_entry.phy[j].mat = csr.tlbelo[j].mat;
            new_entry.phy[j].d   = csr.tlbelo[j].d;
            new_entry.phy[j].v   = csr.tlbelo[j].v;
        end
    end

    always_comb begin
        for (int i = 0; i < `TLB_ENTRY_NUM; i++) begin
            case (exec.inv_op)
                3'd0, 3'd1: inv_hit[i] = 1'b1;
                3'd2: inv_hit[i] = entries[i].g;
                3'd3: inv_hit[i] = ~entries[i].g;
                3'd4: inv_hit[i] = ~entries[i].g && (entries[i].asid == exec.inv_asid);
                3'd5: inv_hit[i] = ~entries[i].g && (entries[i].asid == exec.inv_asid)
                                   && (entries[i].vppn == exec.inv_vppn);
                3'd6: inv_hit[i] = (entries[i].g || (entries[i].asid == exec.inv_asid))
                                   && (entries[i].vppn == exec.inv_vppn);
                default: inv_hit[i] = 1'b0;
            endcase
        end
    end

    // later entries overwrite earlier ones, so the highest match wins
    always_comb begin
        srch_found = 1'b0;
        srch_idx   = '0;
        for (int i = 0; i < `TLB_ENTRY_NUM; i++) begin
            if (entries[i].e && (entries[i].g || (entries[i].asid == csr.asid.asid))
                && (entries[i].vppn == csr.tlbehi.vppn)) begin
                srch_found = 1'b1;
                srch_idx   = tlb_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `TLB_ENTRY_NUM; i++) begin
                entries[i].e <= 1'b0;
            end
        end else if (do_wr || do_fill) begin
            entries[wr_idx] <= new_entry;
        end else if (do_inv) begin
            for (int i = 0; i < `TLB_ENTRY_NUM; i++) begin
                if (inv_hit[i]) begin
                    entries[i].e <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= exec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_valid) begin
            res.op       <= exec.op;
            res.csr_sel  <= exec.csr_sel;
            res.data     <= exec.data;
            res.found    <= srch_found;
            res.srch_idx <= srch_idx;
            res.rd_entry <= entries[csr.tlbidx.index];
        end
    end

    // a request that decodes to no op or to two ops is malformed
    a_one_op: assert property (@(posedge clk) disable iff (reset)
        exec_valid |-> $onehot({exec.op == CSR_WR, do_srch, do_rd, do_wr, do_fill, do_inv}));

endmodule

// File: tlb_cmd_decode.sv
`timescale 1ns/100ps
`include "tlb_defines.svh"

module tlb_cmd_decode (
    input  logic               clk,
    input  logic               reset,
    input  logic               cmd_valid,
    input  tlb_pkg::tlb_cmd_t  cmd,
    output logic               cmd_credit,
    input  logic               retire,
    output logic               exec_valid,
    output tlb_pkg::tlb_exec_t exec
);
    import tlb_pkg::*;

    localparam int PTR_WID = $clog2(`TLB_CMD_CREDITS);

    tlb_cmd_t           fifo_mem [`TLB_CMD_CREDITS];
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic [PTR_WID:0]   count;
    issue_state_e       state;
    tlb_cmd_t           head;
    logic               pop;

    assign head = fifo_mem[rd_ptr];
    // the next command may leave on the same edge that sees the retire
    assign pop = (count != '0) && ((state == IDLE) || retire);

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            fifo_mem[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            state      <= IDLE;
            cmd_credit <= 1'b0;
            exec_valid <= 1'b0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
                state  <= BUSY;
            end else if (retire) begin
                state <= IDLE;
            end
            count      <= count + (PTR_WID+1)'(cmd_valid) - (PTR_WID+1)'(pop);
            cmd_credit <= pop;  // one credit back per command leaving the FIFO
            exec_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            exec.op       <= head.op;
            exec.csr_sel  <= head.csr_sel;
            exec.data     <= head.data;
            exec.inv_asid <= head.inv_asid;
            exec.inv_vppn <= head.inv_vppn;
            exec.inv_op   <= (head.inv_op > 5'd6) ? 3'd7 : head.inv_op[2:0];  // undefined ops do nothing
        end
    end

    // a host that respects its credits never finds the FIFO full
    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        cmd_valid |-> count != (PTR_WID+1)'(`TLB_CMD_CREDITS));

    a_no_retire_idle: assert property (@(posedge clk) disable iff (reset)
        retire |-> state == BUSY);

endmodule

// File: tlb_pkg.sv
`include "tlb_defines.svh"

package tlb_pkg;

    typedef logic [`TLB_IDX_WID-1:0]  tlb_idx_t;
    typedef logic [`TLB_VPPN_WID-1:0] vppn_t;
    typedef logic [`TLB_PPN_WID-1:0]  ppn_t;
    typedef logic [`TLB_ASID_WID-1:0] asid_t;

    typedef enum logic [2:0] {CSR_WR, SRCH, RD, WR, FILL, INV} tlb_op_e;

    typedef enum logic [2:0] {
        SEL_ASID, SEL_TLBEHI, SEL_TLBELO0, SEL_TLBELO1, SEL_TLBIDX, SEL_ESTAT
    } csr_sel_e;

    typedef enum logic {IDLE, BUSY} issue_state_e;

    typedef struct packed {
        logic [`TLB_DATA_WID-`TLB_ASID_WID-1:0] rsv;
        asid_t                                  asid;
    } csr_asid_t;

    typedef struct packed {
        vppn_t                                  vppn;
        logic [`TLB_DATA_WID-`TLB_VPPN_WID-1:0] rsv;
    } csr_tlbehi_t;

    // same layout as the architectural TLBELO, v sits in bit 0
    typedef struct packed {
        logic [`TLB_DATA_WID-`TLB_PPN_WID-9:0] rsv_hi;
        ppn_t                                  ppn;
        logic                                  rsv;
        logic                                  g;
        logic [1:0]                            mat;
        logic [1:0]                            plv;
        logic                                  d;
        logic                                  v;
    } csr_tlbelo_t;

    typedef struct packed {
        logic                                ne;
        logic                                rsv1;
        logic [`TLB_PS_WID-1:0]              ps;
        logic [`TLB_DATA_WID-`TLB_PS_WID-`TLB_IDX_WID-3:0] rsv0;
        tlb_idx_t                            index;
    } csr_tlbidx_t;

    typedef struct packed {
        logic [`TLB_DATA_WID-`TLB_ECODE_WID-17:0] rsv_hi;
        logic [`TLB_ECODE_WID-1:0]                ecode;  // TLBR marks a refill
        logic [15:0]                              rsv_lo;
    } csr_estat_t;

    typedef struct packed {
        csr_asid_t         asid;
        csr_tlbehi_t       tlbehi;
        csr_tlbelo_t [1:0] tlbelo;
        csr_tlbidx_t       tlbidx;
        csr_estat_t        estat;
    } tlb_csr_t;

    typedef struct packed {
        ppn_t       ppn;
        logic [1:0] plv;
        logic [1:0] mat;
        logic       d;
        logic       v;
    } tlb_phy_t;

    typedef struct packed {
        logic                   e;
        logic                   g;
        vppn_t                  vppn;
        logic [`TLB_PS_WID-1:0] ps;
        asid_t                  asid;
        tlb_phy_t [1:0]         phy;
    } tlb_entry_t;

    typedef struct packed {
        tlb_op_e                  op;
        csr_sel_e                 csr_sel;
        logic [`TLB_DATA_WID-1:0] data;
        logic [4:0]               inv_op;
        asid_t                    inv_asid;
        vppn_t                    inv_vppn;
    } tlb_cmd_t;

    typedef struct packed {
        tlb_op_e                  op;
        csr_sel_e                 csr_sel;
        logic [`TLB_DATA_WID-1:0] data;
        logic [2:0]               inv_op;  // 7 is the no-op slot
        asid_t                    inv_asid;
        vppn_t                    inv_vppn;
    } tlb_exec_t;

    typedef struct packed {
        tlb_op_e                  op;
        csr_sel_e                 csr_sel;
        logic [`TLB_DATA_WID-1:0] data;
        logic                     found;
        tlb_idx_t                 srch_idx;
        tlb_entry_t               rd_entry;
    } tlb_result_t;

endpackage

// File: tlb_defines.svh
`ifndef TLB_DEFINES_SVH
`define TLB_DEFINES_SVH

// array geometry
`define TLB_ENTRY_NUM 16
`define TLB_IDX_WID 4

// command port, FIFO depth equals the credits the host starts with
`define TLB_CMD_CREDITS 4

// entry and CSR field widths
`define TLB_VPPN_WID 19
`define TLB_PPN_WID 20
`define TLB_ASID_WID 10
`define TLB_PS_WID 6

// CSR word and exception code
`define TLB_DATA_WID 32
`define TLB_ECODE_WID 6
`define TLB_ECODE_TLBR 6'h3f

`endif
